/* Bender.yml */
package:
  name: arcade_shell

sources:
  - src/arcade_pkg.sv
  - src/video_pkg.sv
  - src/key_mapper.sv
  - src/rom_loader.sv
  - src/video_out.sv
  - src/audio_dac.sv
  - src/arcade_shell.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/arcade_shell_sva.sv
      - bench/arcade_shell_tb.sv

/* bench/arcade_shell_sva.sv */
// Concurrent checks on ROM loader and video outputs of the shell
// Bound into every arcade_shell instance

`timescale 1ns/1ps

module arcade_shell_sva (
	input logic                              clk_sys,
	input logic                              arst_n,
	input logic                              rom_rd,
	input logic [arcade_pkg::ROM_DATA_W-1:0] rom_data,
	input logic                              game_reset,
	input arcade_pkg::load_state_e           load_state,
	input logic                              game_blankn,
	input logic [video_pkg::COLOR_OUT_W-1:0] vga_r,
	input logic [video_pkg::COLOR_OUT_W-1:0] vga_g,
	input logic [video_pkg::COLOR_OUT_W-1:0] vga_b
);
	import arcade_pkg::*;

	int sva_errors = 0;

	rom_data_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!$past(rom_rd) |-> $stable(rom_data))
	else begin
		sva_errors++;
		$error("rom_data changed without a read");
	end

	blank_black: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!game_blankn |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
	else begin
		sva_errors++;
		$error("vga colour not black after blanking");
	end

	reset_until_ready: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(load_state != LOAD_READY) |-> game_reset)
	else begin
		sva_errors++;
		$error("game_reset low while loader not ready");
	end

endmodule

bind arcade_shell arcade_shell_sva u_sva (
	.clk_sys     (clk_sys),
	.arst_n      (arst_n),
	.rom_rd      (rom_rd),
	.rom_data    (rom_data),
	.game_reset  (game_reset),
	.load_state  (u_rom_loader.state),
	.game_blankn (game_blankn),
	.vga_r       (vga_r),
	.vga_g       (vga_g),
	.vga_b       (vga_b)
);

/* bench/arcade_shell_tb.sv */
// Testbench for the arcade board shell
// Loads and reads the ROM, drives keys, joysticks, video and audio against reference models

`timescale 1ns/1ps

module arcade_shell_tb;
	import arcade_pkg::*;
	import video_pkg::*;

	localparam int ROM_ADDR_W  = 10;
	localparam int ROM_BYTES   = 2**ROM_ADDR_W;
	localparam int N_READS     = 200;
	localparam int N_KEYS      = 300;
	localparam int N_JOY       = 100;
	localparam int N_VIDEO     = 600;
	localparam int TEST_CYCLES = ROM_BYTES + 2 * N_READS + N_KEYS + N_JOY + N_VIDEO + 6 * 261;
	localparam int MARGIN      = 200;

	logic clk_sys, arst_n;
	logic ioctl_download, ioctl_wr, reset_req, rom_rd, game_reset;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [ROM_DATA_W-1:0] ioctl_dout, rom_data;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic key_strobe, key_pressed;
	logic [7:0] key_code, joystick_0, joystick_1, audio_sample;
	logic [NUM_BUTTONS-1:0] game_buttons;
	logic [COLOR_IN_W-1:0] game_r, game_g;
	logic [COLOR_IN_W-2:0] game_b;
	logic game_hs, game_vs, game_blankn, vga_hs, vga_vs, audio_l, audio_r;
	scanline_e scanlines;
	logic [COLOR_OUT_W-1:0] vga_r, vga_g, vga_b;

	logic [ROM_DATA_W-1:0] rom_image [ROM_BYTES];
	bit key_held [256];
	key_code_e mapped_codes [$];
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;

	tb_clock clk_gen (.clk_sys(clk_sys), .arst_n(arst_n));

	arcade_shell #(.ROM_ADDR_W(ROM_ADDR_W)) dut0 (.*);

	function automatic logic [NUM_BUTTONS-1:0] expected_buttons(input logic [7:0] j0, j1);
		logic [NUM_BUTTONS-1:0] b;
		logic [7:0] j;
		j = j0 | j1;
		b = '0;
		b[BTN_UP]          = key_held[KEY_UP] | j[3];
		b[BTN_DOWN]        = key_held[KEY_DOWN] | j[2];
		b[BTN_REVERSE]     = key_held[KEY_LEFT] | key_held[KEY_RIGHT] | j[1] | j[0];
		b[BTN_FIRE]        = key_held[KEY_SPACE] | j[4];
		b[BTN_THRUST]      = key_held[KEY_ALT] | j[5];
		b[BTN_SMART_BOMB]  = key_held[KEY_CTRL] | j[6];
		b[BTN_HYPERSPACE]  = key_held[KEY_LSHIFT] | j[7];
		b[BTN_COIN]        = key_held[KEY_ESC];
		b[BTN_START1]      = key_held[KEY_F1];
		b[BTN_START2]      = key_held[KEY_F2];
		b[BTN_ADVANCE]     = key_held[KEY_A];
		b[BTN_AUTO_UP]     = key_held[KEY_U];
		b[BTN_SCORE_RESET] = key_held[KEY_H];
		return b;
	endfunction

	function automatic logic [COLOR_OUT_W-1:0] expected_colour(input logic [COLOR_IN_W-1:0] c,
	                                                          input logic blankn, odd,
	                                                          input scanline_e mode);
		logic [COLOR_OUT_W-1:0] v;
		v = blankn ? {c, c} : '0;
		if (odd && mode == SCAN_25)
			v = v - v / 4;
		else if (odd && mode == SCAN_50)
			v = v - v / 2;
		else if (odd && mode == SCAN_75)
			v = v - (v / 2 + v / 4);
		return v;
	endfunction

	task automatic check_rom(input logic [ROM_DATA_W-1:0] got, exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s rom_data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_buttons(input logic [NUM_BUTTONS-1:0] got, exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s buttons %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_colour(input logic [COLOR_OUT_W-1:0] r, g, b, er, eg, eb);
		if ({r, g, b} !== {er, eg, eb}) begin
			errors++;
			$display("Mismatch at %0t: vga %h/%h/%h, expected %h/%h/%h",
			         $time, r, g, b, er, eg, eb);
		end
	endtask

	task automatic check_ones(input int count, input logic [7:0] sample);
		if (count < int'(sample) - 1 || count > int'(sample) + 1) begin
			errors++;
			$display("Mismatch at %0t: %0d ones for sample %0d", $time, count, sample);
		end
	endtask

	task automatic check_bit(input logic got, exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("Test %s: ok", name);
		end else begin
			failed_tests++;
			$display("Test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		@(negedge clk_sys);
		check_bit(game_reset, 1'b1, "game_reset in reset");
		wait (arst_n === 1'b1);
		for (int a = 0; a < ROM_BYTES; a++) begin
			@(negedge clk_sys);
			check_bit(game_reset, 1'b1, "game_reset during download");
			ioctl_download = 1'b1;
			ioctl_wr       = 1'b1;
			ioctl_addr     = IOCTL_ADDR_W'(a);
			ioctl_dout     = rom_image[a];
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		@(negedge clk_sys);
		check_bit(game_reset, 1'b1, "game_reset one edge after load");
		@(negedge clk_sys);
		check_bit(game_reset, 1'b0, "game_reset two edges after load");
		reset_req = 1'b1;
		@(negedge clk_sys);
		check_bit(game_reset, 1'b1, "game_reset with reset_req");
		reset_req = 1'b0;
		@(negedge clk_sys);
		check_bit(game_reset, 1'b0, "game_reset after reset_req");
		report_test("reset", err0);
	endtask

	task automatic test_rom();
		int err0;
		int addr;
		logic [ROM_DATA_W-1:0] held;
		err0 = errors;
		for (int i = 0; i < N_READS; i++) begin
			@(negedge clk_sys);
			addr     = $urandom_range(0, ROM_BYTES - 1);
			rom_rd   = 1'b1;
			rom_addr = ROM_ADDR_W'(addr);
			@(negedge clk_sys);
			rom_rd = 1'b0;
			check_rom(rom_data, rom_image[addr], "read");
		end
		held = rom_data;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk_sys);
			check_rom(rom_data, held, "read during download");
			ioctl_download = 1'b1;
			ioctl_wr       = i[0]; // Rewrites image bytes unchanged
			ioctl_addr     = IOCTL_ADDR_W'(i);
			ioctl_dout     = rom_image[i];
			rom_rd         = 1'b1;
			rom_addr       = ROM_ADDR_W'($urandom_range(0, ROM_BYTES - 1));
		end
		@(negedge clk_sys);
		check_rom(rom_data, held, "read during download");
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		rom_rd         = 1'b0;
		report_test("rom", err0);
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_strobe     = 1'b1;
		key_code       = code;
		key_pressed    = pressed;
		key_held[code] = pressed;
	endtask

	task automatic test_buttons(input string name, input int count, input bit with_joy);
		int err0;
		int pick;
		err0 = errors;
		for (int i = 0; i <= count; i++) begin
			@(negedge clk_sys);
			if (i > 0)
				check_buttons(game_buttons, expected_buttons(joystick_0, joystick_1), name);
			key_strobe = 1'b0;
			if (i < count) begin
				pick = $urandom_range(0, mapped_codes.size() - 1);
				if (with_joy) begin
					joystick_0 = 8'($urandom) & 8'($urandom); // Sparse directions
					joystick_1 = 8'($urandom) & 8'($urandom);
					if ($urandom_range(0, 1))
						send_key(mapped_codes[pick], $urandom_range(0, 1));
				end else if (i < mapped_codes.size())
					send_key(mapped_codes[i], 1'b1);
				else if ($urandom_range(0, 3) == 0)
					send_key(8'($urandom), $urandom_range(0, 1));
				else
					send_key(mapped_codes[pick], $urandom_range(0, 1));
			end
		end
		key_strobe = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		report_test(name, err0);
	endtask

	task automatic test_video();
		int err0;
		logic [COLOR_OUT_W-1:0] er, eg, eb;
		logic ehs, evs;
		logic odd = 1'b0;
		logic hs_prev = 1'b0;
		err0 = errors;
		for (int i = 0; i <= N_VIDEO; i++) begin
			@(negedge clk_sys);
			if (i > 0) begin
				check_colour(vga_r, vga_g, vga_b, er, eg, eb);
				check_bit(vga_hs, ehs, "vga_hs");
				check_bit(vga_vs, evs, "vga_vs");
			end
			game_r      = COLOR_IN_W'($urandom);
			game_g      = COLOR_IN_W'($urandom);
			game_b      = (COLOR_IN_W - 1)'($urandom);
			game_blankn = $urandom_range(0, 7) != 0;
			game_hs     = (i % 20) < 2;
			game_vs     = (i % 200) < 3;
			scanlines   = scanline_e'($urandom_range(0, 3));
			er  = expected_colour(game_r, game_blankn, odd, scanlines);
			eg  = expected_colour(game_g, game_blankn, odd, scanlines);
			eb  = expected_colour({game_b, game_b[1]}, game_blankn, odd, scanlines);
			ehs = game_hs;
			evs = game_vs;
			if (game_vs)
				odd = 1'b0;
			else if (game_hs && !hs_prev)
				odd = !odd;
			hs_prev = game_hs;
		end
		report_test("video", err0);
	endtask

	task automatic test_audio();
		int err0;
		int count;
		logic [7:0] samples [6] = '{8'd0, 8'd255, 8'd1, 8'd64, 8'd128, 8'd201};
		err0 = errors;
		foreach (samples[s]) begin
			@(negedge clk_sys);
			audio_sample = samples[s];
			repeat (4) @(negedge clk_sys); // Let the accumulator settle
			count = 0;
			repeat (256) begin
				@(negedge clk_sys);
				count += audio_l;
				check_bit(audio_r, audio_l, "audio_r");
			end
			check_ones(count, samples[s]);
		end
		report_test("audio", err0);
	endtask

	initial begin
		#((TEST_CYCLES + MARGIN) * 10);
		$display("Timeout after %0d cycles, tests did not complete", TEST_CYCLES + MARGIN);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		key_code_e k;
		void'($urandom(38));
		{ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, reset_req, rom_rd, rom_addr} = '0;
		{key_strobe, key_pressed, key_code, joystick_0, joystick_1, audio_sample} = '0;
		{game_r, game_g, game_b, game_hs, game_vs, game_blankn} = '0;
		scanlines = SCAN_OFF;
		foreach (rom_image[a])
			rom_image[a] = 8'($urandom);
		k = k.first();
		repeat (k.num()) begin
			mapped_codes.push_back(k);
			k = k.next();
		end
		test_reset();
		test_rom();
		test_buttons("keys", N_KEYS, 1'b0);
		test_buttons("joystick", N_JOY, 1'b1);
		test_video();
		test_audio();
		errors += dut0.u_sva.sva_errors;
		$display("Tests: %0d run, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
// Testbench clock and reset source
// 10 ns clk_sys, arst_n held low for the first four cycles

`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1; // Released away from the active edge
	end

endmodule

/* src/arcade_pkg.sv */
// Arcade shell control and memory definitions
// Game button indices, mapped PS/2 set-2 key codes, ROM loader states and widths

package arcade_pkg;

	localparam int NUM_BUTTONS  = 13;
	localparam int IOCTL_ADDR_W = 25;
	localparam int ROM_DATA_W   = 8;

	// Bit positions in the game button vector
	typedef enum logic [3:0] {
		BTN_UP          = 4'd0,
		BTN_DOWN        = 4'd1,
		BTN_REVERSE     = 4'd2,
		BTN_FIRE        = 4'd3,
		BTN_THRUST      = 4'd4,
		BTN_SMART_BOMB  = 4'd5,
		BTN_HYPERSPACE  = 4'd6,
		BTN_COIN        = 4'd7,
		BTN_START1      = 4'd8,
		BTN_START2      = 4'd9,
		BTN_ADVANCE     = 4'd10,
		BTN_AUTO_UP     = 4'd11,
		BTN_SCORE_RESET = 4'd12
	} btn_e;

	typedef enum logic [7:0] {
		KEY_F1     = 8'h05,
		KEY_F2     = 8'h06,
		KEY_ALT    = 8'h11,
		KEY_LSHIFT = 8'h12,
		KEY_CTRL   = 8'h14,
		KEY_A      = 8'h1C,
		KEY_SPACE  = 8'h29,
		KEY_H      = 8'h33,
		KEY_U      = 8'h3C,
		KEY_LEFT   = 8'h6B,
		KEY_DOWN   = 8'h72,
		KEY_RIGHT  = 8'h74,
		KEY_UP     = 8'h75,
		KEY_ESC    = 8'h76
	} key_code_e;

	typedef enum logic [1:0] {
		LOAD_EMPTY  = 2'd0,
		LOAD_ACTIVE = 2'd1,
		LOAD_READY  = 2'd2
	} load_state_e;

endpackage

/* src/arcade_shell.sv */
// Arcade board shell top level
// ROM loader, key mapper, video formatter and audio DAC around a game core

`timescale 1ns/1ps

module arcade_shell #(
	parameter int ROM_ADDR_W = 15,
	parameter int DAC_W      = 8
) (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                ioctl_download,
	input  logic                                ioctl_wr,
	input  logic [arcade_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [arcade_pkg::ROM_DATA_W-1:0]   ioctl_dout,
	input  logic                                reset_req,
	input  logic                                rom_rd,
	input  logic [ROM_ADDR_W-1:0]               rom_addr,
	output logic [arcade_pkg::ROM_DATA_W-1:0]   rom_data,
	output logic                                game_reset,
	input  logic                                key_strobe,
	input  logic                                key_pressed,
	input  logic [7:0]                          key_code,
	input  logic [7:0]                          joystick_0,
	input  logic [7:0]                          joystick_1,
	output logic [arcade_pkg::NUM_BUTTONS-1:0]  game_buttons,
	input  logic [video_pkg::COLOR_IN_W-1:0]    game_r,
	input  logic [video_pkg::COLOR_IN_W-1:0]    game_g,
	input  logic [video_pkg::COLOR_IN_W-2:0]    game_b,
	input  logic                                game_hs,
	input  logic                                game_vs,
	input  logic                                game_blankn,
	input  video_pkg::scanline_e                scanlines,
	output logic [video_pkg::COLOR_OUT_W-1:0]   vga_r,
	output logic [video_pkg::COLOR_OUT_W-1:0]   vga_g,
	output logic [video_pkg::COLOR_OUT_W-1:0]   vga_b,
	output logic                                vga_hs,
	output logic                                vga_vs,
	input  logic [DAC_W-1:0]                    audio_sample,
	output logic                                audio_l,
	output logic                                audio_r
);

	logic dac_bit;

	rom_loader #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_rom_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.rom_rd         (rom_rd),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.game_reset     (game_reset)
	);

	key_mapper u_key_mapper (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_code     (key_code),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.game_buttons (game_buttons)
	);

	video_out u_video_out (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.game_r      (game_r),
		.game_g      (game_g),
		.game_b      (game_b),
		.game_hs     (game_hs),
		.game_vs     (game_vs),
		.game_blankn (game_blankn),
		.scanlines   (scanlines),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs)
	);

	audio_dac #(
		.DAC_W(DAC_W)
	) u_audio_dac (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.audio_sample (audio_sample),
		.dac_bit      (dac_bit)
	);

	assign audio_l = dac_bit; // Mono to both channels
	assign audio_r = dac_bit;

endmodule

/* src/audio_dac.sv */
// First-order sigma-delta audio DAC
// Carry out of the sample accumulator is the one-bit stream

`timescale 1ns/1ps

module audio_dac #(
	parameter int DAC_W = 8
) (
	input  logic             clk_sys,
	input  logic             arst_n,
	input  logic [DAC_W-1:0] audio_sample,
	output logic             dac_bit
);

	logic [DAC_W:0] acc;

	// Residue is kept, carry is dropped each cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_W-1:0]} + {1'b0, audio_sample};
	end

	assign dac_bit = acc[DAC_W]; // Registered carry

endmodule

/* src/key_mapper.sv */
// Keyboard and joystick to game button mapping
// Latches key state on scan-code strobes, ORs in both joysticks

`timescale 1ns/1ps

module key_mapper (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic                             key_strobe,
	input  logic                             key_pressed,
	input  logic [7:0]                       key_code,
	input  logic [7:0]                       joystick_0,
	input  logic [7:0]                       joystick_1,
	output logic [arcade_pkg::NUM_BUTTONS-1:0] game_buttons
);
	import arcade_pkg::*;

	logic key_up, key_down, key_left, key_right;
	logic key_fire, key_thrust, key_bomb, key_hyper;
	logic key_coin, key_start1, key_start2;
	logic key_advance, key_auto_up, key_score_reset;
	logic [7:0] joy;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_up          <= 1'b0;
			key_down        <= 1'b0;
			key_left        <= 1'b0;
			key_right       <= 1'b0;
			key_fire        <= 1'b0;
			key_thrust      <= 1'b0;
			key_bomb        <= 1'b0;
			key_hyper       <= 1'b0;
			key_coin        <= 1'b0;
			key_start1      <= 1'b0;
			key_start2      <= 1'b0;
			key_advance     <= 1'b0;
			key_auto_up     <= 1'b0;
			key_score_reset <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:     key_up          <= key_pressed;
				KEY_DOWN:   key_down        <= key_pressed;
				KEY_LEFT:   key_left        <= key_pressed;
				KEY_RIGHT:  key_right       <= key_pressed;
				KEY_SPACE:  key_fire        <= key_pressed;
				KEY_ALT:    key_thrust      <= key_pressed;
				KEY_CTRL:   key_bomb        <= key_pressed;
				KEY_LSHIFT: key_hyper       <= key_pressed;
				KEY_ESC:    key_coin        <= key_pressed;
				KEY_F1:     key_start1      <= key_pressed;
				KEY_F2:     key_start2      <= key_pressed;
				KEY_A:      key_advance     <= key_pressed;
				KEY_U:      key_auto_up     <= key_pressed;
				KEY_H:      key_score_reset <= key_pressed;
				default:    ; // Unmapped codes
			endcase
		end
	end

	assign joy = joystick_0 | joystick_1;

	always_comb begin
		game_buttons                  = '0;
		game_buttons[BTN_UP]          = key_up | joy[3];
		game_buttons[BTN_DOWN]        = key_down | joy[2];
		game_buttons[BTN_REVERSE]     = key_left | key_right | joy[1] | joy[0];
		game_buttons[BTN_FIRE]        = key_fire | joy[4];
		game_buttons[BTN_THRUST]      = key_thrust | joy[5];
		game_buttons[BTN_SMART_BOMB]  = key_bomb | joy[6];
		game_buttons[BTN_HYPERSPACE]  = key_hyper | joy[7];
		game_buttons[BTN_COIN]        = key_coin;
		game_buttons[BTN_START1]      = key_start1;
		game_buttons[BTN_START2]      = key_start2;
		game_buttons[BTN_ADVANCE]     = key_advance;
		game_buttons[BTN_AUTO_UP]     = key_auto_up;
		game_buttons[BTN_SCORE_RESET] = key_score_reset;
	end

endmodule

/* src/rom_loader.sv */
// Game ROM store with host download path
// Serves core reads and holds the core in reset until a load completes

`timescale 1ns/1ps

module rom_loader #(
	parameter int ROM_ADDR_W = 15
) (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              ioctl_download,
	input  logic                              ioctl_wr,
	input  logic [arcade_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [arcade_pkg::ROM_DATA_W-1:0]   ioctl_dout,
	input  logic                              reset_req,
	input  logic                              rom_rd,
	input  logic [ROM_ADDR_W-1:0]             rom_addr,
	output logic [arcade_pkg::ROM_DATA_W-1:0]   rom_data,
	output logic                              game_reset
);
	import arcade_pkg::*;

	logic [ROM_DATA_W-1:0] rom_mem [2**ROM_ADDR_W];
	logic [ROM_ADDR_W-1:0] mem_addr;
	logic                  download_q;
	load_state_e           state;

	// Host owns the address while a download runs
	assign mem_addr = ioctl_download ? ioctl_addr[ROM_ADDR_W-1:0] : rom_addr;

	always_ff @(posedge clk_sys) begin
		if (ioctl_download && ioctl_wr)
			rom_mem[mem_addr] <= ioctl_dout;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			rom_data <= '0;
		else if (rom_rd && !ioctl_download)
			rom_data <= rom_mem[mem_addr]; // Holds between reads
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			download_q <= 1'b0;
			state      <= LOAD_EMPTY;
			game_reset <= 1'b1;
		end else begin
			download_q <= ioctl_download;
			case (state)
				LOAD_EMPTY:  if (ioctl_download) state <= LOAD_ACTIVE;
				LOAD_ACTIVE: if (download_q && !ioctl_download) state <= LOAD_READY;
				LOAD_READY:  if (ioctl_download) state <= LOAD_ACTIVE; // Reload
				default:     state <= LOAD_EMPTY;
			endcase
			// Download term reasserts reset on the same edge the loader leaves READY
			game_reset <= reset_req | (state != LOAD_READY) | ioctl_download;
		end
	end

endmodule

/* src/video_out.sv */
// Board video formatter
// Blanks and widens 3-3-2 core colour to 6 bits, dims odd lines

`timescale 1ns/1ps

module video_out (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic [video_pkg::COLOR_IN_W-1:0]  game_r,
	input  logic [video_pkg::COLOR_IN_W-1:0]  game_g,
	input  logic [video_pkg::COLOR_IN_W-2:0]  game_b,
	input  logic                              game_hs,
	input  logic                              game_vs,
	input  logic                              game_blankn,
	input  video_pkg::scanline_e              scanlines,
	output logic [video_pkg::COLOR_OUT_W-1:0] vga_r,
	output logic [video_pkg::COLOR_OUT_W-1:0] vga_g,
	output logic [video_pkg::COLOR_OUT_W-1:0] vga_b,
	output logic                              vga_hs,
	output logic                              vga_vs
);
	import video_pkg::*;

	logic                  line_odd;
	logic [COLOR_IN_W-1:0] blue_full;

	function automatic logic [COLOR_OUT_W-1:0] shade(input logic [COLOR_IN_W-1:0] c,
	                                                input logic blankn,
	                                                input logic odd,
	                                                input scanline_e mode);
		logic [COLOR_OUT_W-1:0] v;
		v = blankn ? {c, c} : '0;
		if (odd) begin
			case (mode)
				SCAN_25: v = v - (v >> 2);
				SCAN_50: v = v - (v >> 1);
				SCAN_75: v = v - (v >> 1) - (v >> 2);
				default: ;
			endcase
		end
		return v;
	endfunction

	assign blue_full = {game_b, game_b[COLOR_IN_W-2]}; // Repeat top bit

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			line_odd <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else begin
			// vga_hs is last cycle's game_hs
			if (game_vs)
				line_odd <= 1'b0;
			else if (game_hs && !vga_hs)
				line_odd <= ~line_odd;
			vga_r  <= shade(game_r, game_blankn, line_odd, scanlines);
			vga_g  <= shade(game_g, game_blankn, line_odd, scanlines);
			vga_b  <= shade(blue_full, game_blankn, line_odd, scanlines);
			vga_hs <= game_hs;
			vga_vs <= game_vs;
		end
	end

endmodule

/* src/video_pkg.sv */
// Arcade shell video definitions
// Core and board colour depths, scanline dimming modes

package video_pkg;

	localparam int COLOR_IN_W  = 3; // Red and green, blue is one bit less
	localparam int COLOR_OUT_W = 6;

	// Dimming applied on odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scanline_e;

endpackage

/* verilog.f */
src/arcade_pkg.sv
src/video_pkg.sv
src/key_mapper.sv
src/rom_loader.sv
src/video_out.sv
src/audio_dac.sv
src/arcade_shell.sv
bench/tb_clock.sv
bench/arcade_shell_sva.sv
bench/arcade_shell_tb.sv
